/* hdl/thermal_pkg.sv */
// Frame geometry, pixel and lane index types, credit depths, lane count, round-robin pick
package thermal_pkg;

    // --------------------
    // Frame geometry
    // --------------------
    // Pixels per frame, one word each
    localparam int FRAME_PIXELS = 768;
    // Sensor sends the most significant byte first
    localparam int BYTES_PER_PIXEL = 2;

    // --------------------
    // Flow control and lanes
    // --------------------
    localparam int NUM_LANES = 4;
    // Lane queue depth, also the dispatcher's starting credits per lane
    localparam int LANE_CREDITS = 2;
    // Byte FIFO depth, also the source's starting credits
    localparam int IN_CREDITS = 4;

    typedef logic [7:0]  pixel_byte_t;
    typedef logic [15:0] pixel_raw_t;
    // Position within the frame, doubles as the read address
    typedef logic [9:0]  pixel_idx_t;
    typedef logic [1:0]  lane_id_t;

    // First requesting lane at or after ptr, wrapping around
    // Returns ptr itself when nothing requests
    function automatic lane_id_t rr_pick(input logic [NUM_LANES-1:0] req, input lane_id_t ptr);
        lane_id_t pick;
        lane_id_t cand;
        pick = ptr;
        // Walk backwards so the closest lane to ptr wins
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            cand = lane_id_t'(ptr + i);
            if (req[cand]) pick = cand;
        end
        return pick;
    endfunction

endpackage

/* hdl/float_pkg.sv */
// Single-precision field widths, exponent bias, raw top-bit exponent and float word types
package float_pkg;

    // --------------------
    // IEEE 754 single
    // --------------------
    localparam int FLOAT_EXP_W  = 8;
    localparam int FLOAT_MANT_W = 23;

    // Sign, exponent, fraction
    typedef logic [FLOAT_EXP_W+FLOAT_MANT_W:0] float32_t;
    typedef logic [FLOAT_EXP_W-1:0]            float_exp_t;
    typedef logic [FLOAT_MANT_W-1:0]           float_mant_t;

    localparam int EXP_BIAS = 127;

    // Biased exponent when bit 15 of a raw pixel is the leading one
    localparam int RAW_TOP_EXP = EXP_BIAS + 15;

endpackage

/* hdl/pixel_dispatcher.sv */
// Byte input FIFO, byte pairing into pixels, pixel indexing, credit-based round-robin issue
`timescale 1ns/10ps

module pixel_dispatcher (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                byte_valid,
    input  thermal_pkg::pixel_byte_t            byte_data,
    input  logic [thermal_pkg::NUM_LANES-1:0]   issue_credit,
    output logic                                byte_credit,
    output logic [thermal_pkg::NUM_LANES-1:0]   issue_valid,
    output thermal_pkg::pixel_raw_t             issue_pixel,
    output thermal_pkg::pixel_idx_t             issue_idx,
    output logic                                frame_begin
);
    import thermal_pkg::*;

    localparam int FIFO_PTR_W = $clog2(IN_CREDITS);
    localparam int FIFO_CNT_W = $clog2(IN_CREDITS + 1);
    localparam int BYTE_POS_W = $clog2(BYTES_PER_PIXEL);
    localparam int LANE_CNT_W = $clog2(LANE_CREDITS + 1);

    // --------------------
    // Byte FIFO
    // --------------------
    pixel_byte_t                 byte_mem [IN_CREDITS];
    logic [FIFO_PTR_W-1:0]       fifo_wr_ptr;
    logic [FIFO_PTR_W-1:0]       fifo_rd_ptr;
    logic [FIFO_CNT_W-1:0]       fifo_count;
    logic                        fifo_pop;

    // Pairing and pending pixel
    logic [BYTE_POS_W-1:0]       byte_pos;
    logic                        last_byte;
    pixel_byte_t                 hi_byte;
    logic                        pix_pending;
    pixel_raw_t                  pix_data;
    pixel_idx_t                  pix_idx;
    pixel_idx_t                  pix_count;

    // Lane credits and arbitration
    logic [LANE_CNT_W-1:0]       credit_cnt [NUM_LANES];
    logic [NUM_LANES-1:0]        lane_ready;
    lane_id_t                    rr_ptr;
    lane_id_t                    sel_lane;
    logic                        issue_fire;

    // Low byte closes a pixel
    assign last_byte = (byte_pos == BYTE_POS_W'(BYTES_PER_PIXEL - 1));

    // High bytes always drain, the low byte needs a free pixel slot
    assign fifo_pop = (fifo_count != '0) && (!last_byte || !pix_pending || issue_fire);

    // Source never writes without a credit, so no full check here
    always_ff @(posedge clk) begin
        if (byte_valid) byte_mem[fifo_wr_ptr] <= byte_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fifo_wr_ptr <= '0;
            fifo_rd_ptr <= '0;
            fifo_count  <= '0;
            byte_credit <= 1'b0;
        end else begin
            if (byte_valid) begin
                fifo_wr_ptr <= (fifo_wr_ptr == FIFO_PTR_W'(IN_CREDITS - 1)) ? '0
                                                                             : fifo_wr_ptr + 1'b1;
            end
            if (fifo_pop) begin
                fifo_rd_ptr <= (fifo_rd_ptr == FIFO_PTR_W'(IN_CREDITS - 1)) ? '0
                                                                             : fifo_rd_ptr + 1'b1;
            end
            if (byte_valid && !fifo_pop) begin
                fifo_count <= fifo_count + 1'b1;
            end else if (!byte_valid && fifo_pop) begin
                fifo_count <= fifo_count - 1'b1;
            end
            // Credit goes back the cycle after the byte leaves
            byte_credit <= fifo_pop;
        end
    end

    // --------------------
    // Byte pairing
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            byte_pos    <= '0;
            pix_pending <= 1'b0;
            pix_count   <= '0;
        end else begin
            if (fifo_pop) begin
                byte_pos <= last_byte ? '0 : byte_pos + 1'b1;
            end
            if (fifo_pop && last_byte) begin
                pix_pending <= 1'b1;
                pix_count   <= (pix_count == pixel_idx_t'(FRAME_PIXELS - 1)) ? '0
                                                                              : pix_count + 1'b1;
            end else if (issue_fire) begin
                pix_pending <= 1'b0;
            end
        end
    end

    // Payload only, qualified by byte_pos and pix_pending
    always_ff @(posedge clk) begin
        if (fifo_pop && !last_byte) hi_byte <= byte_mem[fifo_rd_ptr];
        if (fifo_pop && last_byte) begin
            pix_data <= {hi_byte, byte_mem[fifo_rd_ptr]};
            pix_idx  <= pix_count;
        end
    end

    // --------------------
    // Issue to lanes
    // --------------------
    always_comb begin
        for (int n = 0; n < NUM_LANES; n++) begin
            lane_ready[n] = (credit_cnt[n] != '0);
        end
    end

    assign sel_lane   = rr_pick(lane_ready, rr_ptr);
    assign issue_fire = pix_pending && (|lane_ready);

    always_comb begin
        for (int n = 0; n < NUM_LANES; n++) begin
            issue_valid[n] = issue_fire && (sel_lane == lane_id_t'(n));
        end
    end

    // Shared buses, only the strobed lane latches them
    assign issue_pixel = pix_data;
    assign issue_idx   = pix_idx;
    // Pixel 0 going out opens a new frame at the collector
    assign frame_begin = issue_fire && (pix_idx == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= '0;
            for (int n = 0; n < NUM_LANES; n++) begin
                credit_cnt[n] <= LANE_CNT_W'(LANE_CREDITS);
            end
        end else begin
            if (issue_fire) rr_ptr <= sel_lane + 1'b1;
            for (int n = 0; n < NUM_LANES; n++) begin
                // Returned credit and a new issue in the same cycle cancel out
                if (issue_credit[n] && !issue_valid[n]) begin
                    credit_cnt[n] <= credit_cnt[n] + 1'b1;
                end else if (!issue_credit[n] && issue_valid[n]) begin
                    credit_cnt[n] <= credit_cnt[n] - 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/float_convert_lane.sv */
// Conversion lane with a two-entry pixel queue and a bit-serial uint16 to float normalizer
`timescale 1ns/10ps

module float_convert_lane (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     issue_valid,
    input  thermal_pkg::pixel_raw_t  issue_pixel,
    input  thermal_pkg::pixel_idx_t  issue_idx,
    input  logic                     result_take,
    output logic                     issue_credit,
    output logic                     result_valid,
    output float_pkg::float32_t      result_float,
    output thermal_pkg::pixel_idx_t  result_idx
);
    import thermal_pkg::*;
    import float_pkg::*;

    localparam int RAW_W   = $bits(pixel_raw_t);
    localparam int Q_PTR_W = $clog2(LANE_CREDITS);
    localparam int Q_CNT_W = $clog2(LANE_CREDITS + 1);

    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_NORM,
        LANE_HOLD
    } lane_state_t;

    // --------------------
    // Pixel queue
    // --------------------
    pixel_raw_t           q_pixel [LANE_CREDITS];
    pixel_idx_t           q_idx   [LANE_CREDITS];
    logic [Q_PTR_W-1:0]   q_wr_ptr;
    logic [Q_PTR_W-1:0]   q_rd_ptr;
    logic [Q_CNT_W-1:0]   q_count;
    logic                 q_pop;

    // Normalizer
    lane_state_t          state;
    pixel_raw_t           norm_val;
    float_exp_t           exp_val;
    pixel_idx_t           idx_reg;
    float_mant_t          frac;

    // Load only from idle, so a waiting result stalls the queue
    assign q_pop = (state == LANE_IDLE) && (q_count != '0);

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            q_pixel[q_wr_ptr] <= issue_pixel;
            q_idx[q_wr_ptr]   <= issue_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            q_wr_ptr     <= '0;
            q_rd_ptr     <= '0;
            q_count      <= '0;
            issue_credit <= 1'b0;
        end else begin
            if (issue_valid) begin
                q_wr_ptr <= (q_wr_ptr == Q_PTR_W'(LANE_CREDITS - 1)) ? '0 : q_wr_ptr + 1'b1;
            end
            if (q_pop) begin
                q_rd_ptr <= (q_rd_ptr == Q_PTR_W'(LANE_CREDITS - 1)) ? '0 : q_rd_ptr + 1'b1;
            end
            if (issue_valid && !q_pop) begin
                q_count <= q_count + 1'b1;
            end else if (!issue_valid && q_pop) begin
                q_count <= q_count - 1'b1;
            end
            // Slot freed, hand a credit back next cycle
            issue_credit <= q_pop;
        end
    end

    // --------------------
    // Normalizer FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= LANE_IDLE;
        end else begin
            case (state)
                LANE_IDLE: begin
                    // Zero or already-normalized values skip the shift loop
                    if (q_pop) begin
                        if (q_pixel[q_rd_ptr] == '0 || q_pixel[q_rd_ptr][RAW_W-1]) begin
                            state <= LANE_HOLD;
                        end else begin
                            state <= LANE_NORM;
                        end
                    end
                end
                LANE_NORM: begin
                    // Next shift brings the leading one to the top
                    if (norm_val[RAW_W-2]) state <= LANE_HOLD;
                end
                LANE_HOLD: begin
                    if (result_take) state <= LANE_IDLE;
                end
                default: state <= LANE_IDLE;
            endcase
        end
    end

    // One bit per cycle, exponent follows the shift
    always_ff @(posedge clk) begin
        if (q_pop) begin
            norm_val <= q_pixel[q_rd_ptr];
            idx_reg  <= q_idx[q_rd_ptr];
            // Zero encodes as exponent 0 with an empty fraction
            exp_val  <= (q_pixel[q_rd_ptr] == '0) ? '0 : float_exp_t'(RAW_TOP_EXP);
        end else if (state == LANE_NORM) begin
            norm_val <= norm_val << 1;
            exp_val  <= exp_val - 1'b1;
        end
    end

    // Hidden bit dropped, remaining raw bits left-aligned in the fraction
    assign frac         = {norm_val[RAW_W-2:0], {(FLOAT_MANT_W - RAW_W + 1){1'b0}}};
    assign result_float = {1'b0, exp_val, frac};
    assign result_idx   = idx_reg;
    assign result_valid = (state == LANE_HOLD);

endmodule

/* hdl/frame_collector.sv */
// Round-robin result drain, output frame buffer, frame completion count and registered read port
`timescale 1ns/10ps

module frame_collector (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic [thermal_pkg::NUM_LANES-1:0]                   result_valid,
    input  float_pkg::float32_t [thermal_pkg::NUM_LANES-1:0]    result_float,
    input  thermal_pkg::pixel_idx_t [thermal_pkg::NUM_LANES-1:0] result_idx,
    input  logic                                                frame_begin,
    input  thermal_pkg::pixel_idx_t                             rd_addr,
    output logic [thermal_pkg::NUM_LANES-1:0]                   result_take,
    output float_pkg::float32_t                                 rd_data,
    output logic                                                frame_ready
);
    import thermal_pkg::*;
    import float_pkg::*;

    localparam int WR_CNT_W = $clog2(FRAME_PIXELS + 1);

    // --------------------
    // Grant
    // --------------------
    lane_id_t               rr_ptr;
    lane_id_t               sel_lane;
    logic                   wr_en;

    // Buffer and completion tracking
    float32_t               frame_mem [FRAME_PIXELS];
    logic [WR_CNT_W-1:0]    wr_count;

    assign sel_lane = rr_pick(result_valid, rr_ptr);
    assign wr_en    = |result_valid;

    // At most one lane granted per cycle
    always_comb begin
        for (int n = 0; n < NUM_LANES; n++) begin
            result_take[n] = wr_en && (sel_lane == lane_id_t'(n));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= '0;
        end else if (wr_en) begin
            // Start after the lane just served
            rr_ptr <= sel_lane + 1'b1;
        end
    end

    // --------------------
    // Frame buffer
    // --------------------
    // Written in the grant cycle, at the pixel's own position
    always_ff @(posedge clk) begin
        if (wr_en) frame_mem[result_idx[sel_lane]] <= result_float[sel_lane];
    end

    // One-cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= frame_mem[rd_addr];
    end

    // --------------------
    // Completion
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_count    <= '0;
            frame_ready <= 1'b0;
        end else if (frame_begin) begin
            // New frame under way, old contents no longer complete
            wr_count    <= '0;
            frame_ready <= 1'b0;
        end else if (wr_en) begin
            wr_count <= wr_count + 1'b1;
            // Rises the cycle after the last write lands
            if (wr_count == WR_CNT_W'(FRAME_PIXELS - 1)) frame_ready <= 1'b1;
        end
    end

endmodule

/* hdl/thermal_frame_top.sv */
// Thermal frame pipeline top: dispatcher, generated conversion lanes and collector
`timescale 1ns/10ps

module thermal_frame_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     byte_valid,
    input  thermal_pkg::pixel_byte_t byte_data,
    input  thermal_pkg::pixel_idx_t  rd_addr,
    output logic                     byte_credit,
    output float_pkg::float32_t      rd_data,
    output logic                     frame_ready
);
    import thermal_pkg::*;
    import float_pkg::*;

    // --------------------
    // Dispatcher to lanes
    // --------------------
    logic [NUM_LANES-1:0]           issue_valid;
    logic [NUM_LANES-1:0]           issue_credit;
    pixel_raw_t                     issue_pixel;
    pixel_idx_t                     issue_idx;
    logic                           frame_begin;

    // Lanes to collector
    logic [NUM_LANES-1:0]           result_valid;
    logic [NUM_LANES-1:0]           result_take;
    float32_t [NUM_LANES-1:0]       result_float;
    pixel_idx_t [NUM_LANES-1:0]     result_idx;

    pixel_dispatcher pixel_dispatcher_i (
        .clk          (clk),
        .reset        (reset),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .issue_credit (issue_credit),
        .byte_credit  (byte_credit),
        .issue_valid  (issue_valid),
        .issue_pixel  (issue_pixel),
        .issue_idx    (issue_idx),
        .frame_begin  (frame_begin)
    );

    // Identical lanes sharing the issue buses
    for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
        float_convert_lane float_convert_lane_i (
            .clk          (clk),
            .reset        (reset),
            .issue_valid  (issue_valid[n]),
            .issue_pixel  (issue_pixel),
            .issue_idx    (issue_idx),
            .result_take  (result_take[n]),
            .issue_credit (issue_credit[n]),
            .result_valid (result_valid[n]),
            .result_float (result_float[n]),
            .result_idx   (result_idx[n])
        );
    end

    frame_collector frame_collector_i (
        .clk          (clk),
        .reset        (reset),
        .result_valid (result_valid),
        .result_float (result_float),
        .result_idx   (result_idx),
        .frame_begin  (frame_begin),
        .rd_addr      (rd_addr),
        .result_take  (result_take),
        .rd_data      (rd_data),
        .frame_ready  (frame_ready)
    );

endmodule

/* tb/thermal_frame_model.svh */
// Testbench model: Galois LFSR step and reference uint16 to single-precision conversion
`ifndef THERMAL_FRAME_MODEL_SVH
`define THERMAL_FRAME_MODEL_SVH

// --------------------
// Random source
// --------------------
// Taps for x^32 + x^22 + x^2 + x + 1, right-shifting form
localparam logic [31:0] LFSR_POLY = 32'h8020_0003;
localparam logic [31:0] LFSR_SEED = 32'h398b_b755;

// One Galois step, the bit taken is the old bit 0
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] shifted;
    shifted = {1'b0, state[31:1]};
    if (state[0]) begin
        shifted = shifted ^ LFSR_POLY;
    end
    return shifted;
endfunction

// --------------------
// Reference conversion
// --------------------
// Exact float of an unsigned 16-bit value, sign always clear
function automatic float32_t ref_float(input pixel_raw_t raw);
    int          lead;
    pixel_raw_t  aligned;
    float_exp_t  exp_f;
    float_mant_t mant_f;
    if (raw == '0) begin
        return '0;
    end
    // Position of the leading one
    lead = $bits(pixel_raw_t) - 1;
    while (!raw[lead]) begin
        lead = lead - 1;
    end
    exp_f   = float_exp_t'(EXP_BIAS + lead);
    // Leading one moved to bit 15, then dropped as the hidden bit
    aligned = raw << ($bits(pixel_raw_t) - 1 - lead);
    mant_f  = {aligned[14:0], 8'h00};
    return {1'b0, exp_f, mant_f};
endfunction

`endif

/* tb/thermal_frame_tb.sv */
// Testbench for the thermal frame pipeline: clock, reset, byte source, assertions, watchdog, report
`timescale 1ns/10ps

module thermal_frame_tb;
    import thermal_pkg::*;
    import float_pkg::*;

    `include "thermal_frame_model.svh"

    localparam int CLK_PERIOD_NS   = 8;
    localparam int NUM_FRAMES      = 2;
    // Cycle budget per byte that covers idle gaps, stalls and the readback
    localparam int CYCLES_PER_BYTE = 20;
    localparam int WATCHDOG_NS     = NUM_FRAMES * FRAME_PIXELS * BYTES_PER_PIXEL
                                     * CYCLES_PER_BYTE * CLK_PERIOD_NS + 10_000;

    // DUT ports
    logic        clk;
    logic        reset;
    logic        byte_valid;
    pixel_byte_t byte_data;
    pixel_idx_t  rd_addr;
    logic        byte_credit;
    float32_t    rd_data;
    logic        frame_ready;

    // --------------------
    // Source and checker state
    // --------------------
    logic [31:0] lfsr_state       = LFSR_SEED;
    pixel_raw_t  frame_pix [NUM_FRAMES][FRAME_PIXELS];
    int          bytes_sent       = 0;
    int          frame_bytes_sent = 0;
    int          credits_returned = 0;
    int          credit_level;
    logic        first_byte_sent  = 1'b0;
    logic        readback_on      = 1'b0;
    logic        ready_q          = 1'b0;
    int          fall_count       = 0;
    int          check_errors     = 0;
    int          protocol_errors  = 0;

    thermal_frame_top thermal_frame_top_i (
        .clk         (clk),
        .reset       (reset),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .rd_addr     (rd_addr),
        .byte_credit (byte_credit),
        .rd_data     (rd_data),
        .frame_ready (frame_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    // Credits the source holds right now
    assign credit_level = IN_CREDITS - bytes_sent + credits_returned;

    always @(posedge clk) begin
        if (!reset && byte_credit) credits_returned <= credits_returned + 1;
        // Count falling edges of frame_ready
        ready_q <= frame_ready;
        if (ready_q && !frame_ready) fall_count <= fall_count + 1;
    end

    // --------------------
    // Protocol assertions
    // --------------------
    assert property (@(posedge clk) disable iff (reset)
        !first_byte_sent |-> (!frame_ready && !byte_credit))
    else begin
        protocol_errors = protocol_errors + 1;
        $display("Output high after reset before any byte was sent");
    end

    assert property (@(posedge clk) disable iff (reset)
        (credit_level >= 0) && (credit_level <= IN_CREDITS))
    else begin
        protocol_errors = protocol_errors + 1;
        $display("Source credit count out of range: %0d", credit_level);
    end

    // Old frame stays ready until pixel 0 of the next one has gone in
    assert property (@(posedge clk) disable iff (reset)
        $fell(frame_ready) |-> (frame_bytes_sent >= BYTES_PER_PIXEL))
    else begin
        protocol_errors = protocol_errors + 1;
        $display("frame_ready fell before the first pixel of the new frame was sent");
    end

    // rd_data may only move one cycle after rd_addr moved
    assert property (@(posedge clk) disable iff (!readback_on)
        $changed(rd_data) |-> ($past(rd_addr) != $past(rd_addr, 2)))
    else begin
        protocol_errors = protocol_errors + 1;
        $display("rd_data changed without a preceding rd_addr change");
    end

    // --------------------
    // Stimulus helpers
    // --------------------
    // MSB-first bits from the LFSR with one step per bit
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    task automatic make_frame(input int f);
        for (int p = 0; p < FRAME_PIXELS; p++) begin
            frame_pix[f][p] = pixel_raw_t'(take_bits(16));
        end
        // Corner values at the head of the frame
        frame_pix[f][0] = 16'h0000;
        frame_pix[f][1] = 16'h0001;
        frame_pix[f][2] = 16'h8000;
        frame_pix[f][3] = 16'hFFFF;
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic send_byte(input pixel_byte_t b);
        int idle;
        idle = take_bits(2);
        repeat (idle) begin
            @(posedge clk);
            #1;
        end
        // Stall while out of credits
        while (credit_level == 0) begin
            @(posedge clk);
            #1;
        end
        byte_valid       = 1'b1;
        byte_data        = b;
        bytes_sent       = bytes_sent + 1;
        frame_bytes_sent = frame_bytes_sent + 1;
        first_byte_sent  = 1'b1;
        @(posedge clk);
        #1;
        byte_valid = 1'b0;
    endtask

    task automatic send_frame(input int f);
        frame_bytes_sent = 0;
        for (int p = 0; p < FRAME_PIXELS; p++) begin
            send_byte(frame_pix[f][p][15:8]);
            send_byte(frame_pix[f][p][7:0]);
        end
    endtask

    task automatic wait_frame_ready();
        while (!frame_ready) begin
            @(posedge clk);
            #1;
        end
    endtask

    // --------------------
    // Readback
    // --------------------
    task automatic check_word(input string name, input int addr, input pixel_raw_t raw);
        float32_t exp_f;
        exp_f = ref_float(raw);
        assert (rd_data == exp_f) else begin
            check_errors = check_errors + 1;
            $display("FAILED %s addr %0d raw %h expected %h actual %h",
                     name, addr, raw, exp_f, rd_data);
        end
    endtask

    // Word k is checked one cycle after address k goes out
    // Odd addresses stay one more cycle, where rd_data has to hold still
    task automatic read_frame(input int f, input string name);
        int hold;
        repeat (2) @(posedge clk);
        #1;
        readback_on = 1'b1;
        for (int a = 0; a < FRAME_PIXELS; a++) begin
            rd_addr = pixel_idx_t'(a);
            hold    = a % 2;
            for (int h = 0; h <= hold; h++) begin
                @(posedge clk);
                #1;
                check_word(name, a, frame_pix[f][a]);
            end
        end
        readback_on = 1'b0;
    endtask

    task automatic report_and_finish(input bit timed_out);
        $display("Errors: check %0d, protocol %0d", check_errors, protocol_errors);
        if (!timed_out && check_errors == 0 && protocol_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        reset      = 1'b1;
        byte_valid = 1'b0;
        byte_data  = '0;
        rd_addr    = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        // Quiet cycles with the outputs in their post-reset state
        repeat (2) @(posedge clk);
        #1;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            make_frame(f);
            send_frame(f);
            wait_frame_ready();
            // Every byte sent has come back as a credit
            assert (credits_returned == bytes_sent) else begin
                check_errors = check_errors + 1;
                $display("FAILED credit_return frame %0d expected %0d actual %0d",
                         f, bytes_sent, credits_returned);
            end
            read_frame(f, $sformatf("frame%0d_readback", f));
        end
        assert (fall_count == NUM_FRAMES - 1) else begin
            check_errors = check_errors + 1;
            $display("FAILED frame_ready_falls expected %0d actual %0d",
                     NUM_FRAMES - 1, fall_count);
        end
        report_and_finish(1'b0);
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the pipeline stopped making progress",
                 WATCHDOG_NS);
        report_and_finish(1'b1);
    end

endmodule

/* thermal_frame.f */
+incdir+tb
hdl/thermal_pkg.sv
hdl/float_pkg.sv
hdl/pixel_dispatcher.sv
hdl/float_convert_lane.sv
hdl/frame_collector.sv
hdl/thermal_frame_top.sv
tb/thermal_frame_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the thermal frame testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module thermal_frame_tb \
    --Mdir obj_dir \
    -o thermal_frame_sim \
    -f thermal_frame.f

./obj_dir/thermal_frame_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    exit 1
fi
exit 0
